// ==== sources.f ====
dcache_cfg_pkg.sv
dcache_proto_pkg.sv
dcache_array_if.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_ctrl.sv
dcache_top.sv
tb_clock_gen.sv
dcache_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run dcache_tb and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --assert -Wno-fatal --top-module dcache_tb -f sources.f -Mdir obj_dir
	./obj_dir/Vdcache_tb | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;

    localparam int WATCHDOG_NS = 60 * 20 * 4;   // ops x cycles x period
    localparam int RESP_LIMIT  = 60;            // cycles per request

    logic                              w_Selector2_fire_2;
    logic                              rstn;
    logic                              i_req_valid;
    logic                              i_req_load;
    logic [dcache_cfg_pkg::ADDR_W-1:0] i_req_addr;
    logic [dcache_cfg_pkg::WORD_W-1:0] i_store_data;
    logic [dcache_cfg_pkg::MASK_W-1:0] i_store_mask;
    logic [dcache_cfg_pkg::SIDX_W-1:0] i_store_index;
    logic                              i_l2_refill_valid;
    dcache_proto_pkg::line_u           i_l2_refill_line;
    logic                              o_req_ready;
    logic                              o_load_valid;
    logic [dcache_cfg_pkg::WORD_W-1:0] o_load_data;
    logic                              o_store_done;
    logic [dcache_cfg_pkg::SIDX_W-1:0] o_store_index;
    logic                              o_wb_valid;
    logic [dcache_cfg_pkg::ADDR_W-1:0] o_wb_addr;
    dcache_proto_pkg::line_u           o_wb_line;
    logic                              o_miss_valid;
    logic [dcache_cfg_pkg::ADDR_W-1:0] o_miss_addr;

    ////////////////////
    // reference model
    dcache_proto_pkg::line_u ref_mem [logic [dcache_cfg_pkg::ADDR_W-1:0]];  // by line address
    bit [dcache_cfg_pkg::TAG_W-1:0]  m_tag   [dcache_cfg_pkg::SETS][dcache_cfg_pkg::WAYS];
    bit                              m_valid [dcache_cfg_pkg::SETS][dcache_cfg_pkg::WAYS];
    bit                              m_dirty [dcache_cfg_pkg::SETS][dcache_cfg_pkg::WAYS];
    bit [dcache_cfg_pkg::PLRU_W-1:0] m_tree  [dcache_cfg_pkg::SETS];
    logic [31:0] lcg_state = 32'h27;
    int          errors = 0;
    int          checks = 0;

    tb_clock_gen clk_gen_i (.o_clk(w_Selector2_fire_2), .o_rstn(rstn));

    dcache_top dut_i (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [dcache_cfg_pkg::ADDR_W-1:0] make_addr(
        input logic [23:0] tag, input logic [4:0] set, input logic [2:0] word);
        return {tag, set, word, 2'b00};
    endfunction

    // heap order: node n has children 2n+1 (lower) and 2n+2 (upper)
    function automatic bit [6:0] tree_touch(input bit [6:0] t, input int way);
        int node;
        bit dir;
        node = 0;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            dir = bit'((way >> lvl) & 1);
            t[node] = !dir;                 // point at the other half
            node = 2 * node + 1 + int'(dir);
        end
        return t;
    endfunction

    function automatic int pick_victim(input int set);
        int node;
        int way;
        way = -1;
        for (int w = dcache_cfg_pkg::WAYS - 1; w >= 0; w--)
            if (!m_valid[set][w]) way = w;
        if (way >= 0) return way;
        node = 0;
        way  = 0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            way  = 2 * way + int'(m_tree[set][node]);
            node = 2 * node + 1 + int'(m_tree[set][node]);
        end
        return way;
    endfunction

    task automatic check_eq(input string test, input string what,
                            input logic [255:0] exp, input logic [255:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", test, what, exp, act);
        end
    endtask

    ////////////////////
    // one request, checked against the model
    task automatic access(input string test, input bit load,
                          input logic [dcache_cfg_pkg::ADDR_W-1:0] addr,
                          input logic [31:0] data, input logic [3:0] mask,
                          input logic [5:0] sidx);
        int set;
        int way;
        int word;
        int cyc;
        int wb_seen;
        bit exp_hit;
        bit exp_wb;
        bit miss_seen;
        bit done;
        logic [dcache_cfg_pkg::ADDR_W-1:0] line_a;
        logic [dcache_cfg_pkg::ADDR_W-1:0] vic_a;
        dcache_proto_pkg::line_u ln;
        set    = int'(addr[9:5]);
        word   = int'(addr[4:2]);
        line_a = {addr[33:5], 5'b0};
        exp_hit = 1'b0;
        way     = 0;
        for (int w = 0; w < dcache_cfg_pkg::WAYS; w++)
            if (m_valid[set][w] && m_tag[set][w] == addr[33:10]) begin
                exp_hit = 1'b1;
                way = w;
            end
        if (!exp_hit) way = pick_victim(set);
        exp_wb = !exp_hit && m_valid[set][way] && m_dirty[set][way];
        vic_a  = {m_tag[set][way], addr[9:5], 5'b0};

        do @(negedge w_Selector2_fire_2); while (!o_req_ready);
        @(posedge w_Selector2_fire_2);
        #1;
        i_req_valid   = 1'b1;
        i_req_load    = load;
        i_req_addr    = addr;
        i_store_data  = data;
        i_store_mask  = mask;
        i_store_index = sidx;
        @(posedge w_Selector2_fire_2);     // accepting edge
        #1 i_req_valid = 1'b0;

        cyc = 0;
        wb_seen = 0;
        miss_seen = 1'b0;
        done = 1'b0;
        while (!done && cyc < RESP_LIMIT) begin
            @(negedge w_Selector2_fire_2);
            cyc++;
            if (o_wb_valid) begin
                wb_seen++;
                ln = ref_mem.exists(vic_a) ? ref_mem[vic_a] : '0;
                check_eq(test, "wb before miss", 0, miss_seen);
                check_eq(test, "wb addr", vic_a, o_wb_addr);
                check_eq(test, "wb line", ln, o_wb_line);
            end
            if (o_miss_valid) begin
                miss_seen = 1'b1;
                check_eq(test, "miss addr", line_a, o_miss_addr);
            end
            if (o_load_valid || o_store_done) begin
                done = 1'b1;
                check_eq(test, "load pulse", load, o_load_valid);
                check_eq(test, "store pulse", !load, o_store_done);
                if (load) begin
                    check_eq(test, "load data", ref_mem[line_a].words[word], o_load_data);
                end else begin
                    check_eq(test, "store index", sidx, o_store_index);
                    ln = ref_mem[line_a];
                    for (int b = 0; b < dcache_cfg_pkg::MASK_W; b++)
                        if (mask[b]) ln.bytes[word * 4 + b] = data[8*b +: 8];
                    ref_mem[line_a] = ln;
                end
            end
        end
        if (!done) begin
            errors++;
            $display("%s: no response to the request at address %h", test, addr);
        end
        check_eq(test, "miss seen", !exp_hit, miss_seen);
        check_eq(test, "wb pulses", exp_wb, wb_seen);
        if (exp_hit) check_eq(test, "hit latency", 2, cyc);

        // model state after the access
        if (!exp_hit) begin
            m_tag[set][way]   = addr[33:10];
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = 1'b0;
        end
        if (!load) m_dirty[set][way] = 1'b1;
        m_tree[set] = tree_touch(m_tree[set], way);
    endtask

    ////////////////////
    // tests
    task automatic test_reset();
        repeat (3) begin
            @(negedge w_Selector2_fire_2);
            check_eq("reset", "ready", 1, o_req_ready);
            check_eq("reset", "pulses", 0,
                     {o_load_valid, o_store_done, o_wb_valid, o_miss_valid});
        end
    endtask

    task automatic test_load_miss_clean();
        access("load_miss_clean", 1'b1, make_addr(24'h1, 5'd3, 3'd2), '0, '0, '0);
    endtask

    task automatic test_load_hit();
        access("load_hit", 1'b1, make_addr(24'h1, 5'd3, 3'd6), '0, '0, '0);
    endtask

    task automatic test_store_mask();
        access("store_mask", 1'b0, make_addr(24'h1, 5'd3, 3'd5), 32'hA5A5_5A5A, 4'b0101, 6'h2a);
        access("store_mask", 1'b0, make_addr(24'h2, 5'd12, 3'd1), 32'h1234_5678, 4'b1100, 6'h13);
        access("store_mask", 1'b1, make_addr(24'h1, 5'd3, 3'd5), '0, '0, '0);
        access("store_mask", 1'b1, make_addr(24'h2, 5'd12, 3'd1), '0, '0, '0);
    endtask

    task automatic test_plru_evict();
        int order [5] = '{3, 6, 1, 0, 5};
        for (int i = 0; i < 8; i++)
            access("plru_evict", 1'b0, make_addr(24'h100 + 24'(i), 5'd7, 3'(i)),
                   lcg_next(), 4'hf, 6'(i));
        foreach (order[k])
            access("plru_evict", 1'b1, make_addr(24'h100 + 24'(order[k]), 5'd7, 3'd0),
                   '0, '0, '0);
        // set is full and dirty, so both of these evict
        access("plru_evict", 1'b0, make_addr(24'h108, 5'd7, 3'd4), 32'hCAFE_F00D, 4'b0011, 6'h3f);
        access("plru_evict", 1'b1, make_addr(24'h109, 5'd7, 3'd1), '0, '0, '0);
    endtask

    ////////////////////
    // L2 model, answers each miss after 1..8 cycles
    initial begin : l2_responder
        logic [dcache_cfg_pkg::ADDR_W-1:0] line_a;
        dcache_proto_pkg::line_u fresh;
        int delay;
        forever begin
            @(negedge w_Selector2_fire_2);
            if (o_miss_valid) begin
                line_a = o_miss_addr;
                if (!ref_mem.exists(line_a)) begin
                    for (int w = 0; w < dcache_cfg_pkg::WORDS; w++)
                        fresh.words[w] = lcg_next();
                    ref_mem[line_a] = fresh;
                end
                delay = 1 + int'(lcg_next() % 32'd8);
                repeat (delay) @(posedge w_Selector2_fire_2);
                #1;
                i_l2_refill_valid = 1'b1;
                i_l2_refill_line  = ref_mem[line_a];
                @(posedge w_Selector2_fire_2);
                #1 i_l2_refill_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        i_req_valid       = 1'b0;
        i_req_load        = 1'b0;
        i_req_addr        = '0;
        i_store_data      = '0;
        i_store_mask      = '0;
        i_store_index     = '0;
        i_l2_refill_valid = 1'b0;
        i_l2_refill_line  = '0;
        @(posedge rstn);
        test_reset();
        test_load_miss_clean();
        test_load_hit();
        test_store_mask();
        test_plru_evict();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rstn
);

    localparam int HALF_NS     = 2;    // 4 ns period
    localparam int RST_CYCLES  = 5;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_NS) o_clk = ~o_clk;
    end

    initial begin
        o_rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1 o_rstn = 1'b1;     // release off the edge
    end

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                                w_Selector2_fire_2,
    input  logic                                rstn,
    // load/store unit
    input  logic                                i_req_valid,
    input  logic                                i_req_load,     // 1 load, 0 store
    input  logic [dcache_cfg_pkg::ADDR_W-1:0]   i_req_addr,
    input  logic [dcache_cfg_pkg::WORD_W-1:0]   i_store_data,
    input  logic [dcache_cfg_pkg::MASK_W-1:0]   i_store_mask,
    input  logic [dcache_cfg_pkg::SIDX_W-1:0]   i_store_index,
    output logic                                o_req_ready,
    output logic                                o_load_valid,
    output logic [dcache_cfg_pkg::WORD_W-1:0]   o_load_data,
    output logic                                o_store_done,
    output logic [dcache_cfg_pkg::SIDX_W-1:0]   o_store_index,
    // L2
    output logic                                o_wb_valid,
    output logic [dcache_cfg_pkg::ADDR_W-1:0]   o_wb_addr,
    output dcache_proto_pkg::line_u             o_wb_line,
    output logic                                o_miss_valid,
    output logic [dcache_cfg_pkg::ADDR_W-1:0]   o_miss_addr,
    input  logic                                i_l2_refill_valid,
    input  dcache_proto_pkg::line_u             i_l2_refill_line
);

    tag_port_if  tag_bus ();
    data_port_if data_bus ();

    dcache_ctrl ctrl_i (
        .w_Selector2_fire_2 (w_Selector2_fire_2),
        .rstn               (rstn),
        .i_req_valid        (i_req_valid),
        .i_req_load         (i_req_load),
        .i_req_addr         (i_req_addr),
        .i_store_data       (i_store_data),
        .i_store_mask       (i_store_mask),
        .i_store_index      (i_store_index),
        .i_l2_refill_valid  (i_l2_refill_valid),
        .i_l2_refill_line   (i_l2_refill_line),
        .o_req_ready        (o_req_ready),
        .o_load_valid       (o_load_valid),
        .o_store_done       (o_store_done),
        .o_wb_valid         (o_wb_valid),
        .o_miss_valid       (o_miss_valid),
        .o_load_data        (o_load_data),
        .o_store_index      (o_store_index),
        .o_wb_addr          (o_wb_addr),
        .o_miss_addr        (o_miss_addr),
        .o_wb_line          (o_wb_line),
        .o_tag              (tag_bus.ctrl),
        .o_data             (data_bus.ctrl)
    );

    dcache_tag_array tag_i (
        .w_Selector2_fire_2 (w_Selector2_fire_2),
        .rstn               (rstn),
        .i_tag              (tag_bus.array)
    );

    dcache_data_array data_i (
        .w_Selector2_fire_2 (w_Selector2_fire_2),
        .i_data             (data_bus.array)
    );

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                w_Selector2_fire_2,
    input  logic                                rstn,
    input  logic                                i_req_valid,
    input  logic                                i_req_load,
    input  logic [dcache_cfg_pkg::ADDR_W-1:0]   i_req_addr,
    input  logic [dcache_cfg_pkg::WORD_W-1:0]   i_store_data,
    input  logic [dcache_cfg_pkg::MASK_W-1:0]   i_store_mask,
    input  logic [dcache_cfg_pkg::SIDX_W-1:0]   i_store_index,
    input  logic                                i_l2_refill_valid,
    input  dcache_proto_pkg::line_u             i_l2_refill_line,
    output logic                                o_req_ready,
    output logic                                o_load_valid,
    output logic                                o_store_done,
    output logic                                o_wb_valid,
    output logic                                o_miss_valid,
    output logic [dcache_cfg_pkg::WORD_W-1:0]   o_load_data,
    output logic [dcache_cfg_pkg::SIDX_W-1:0]   o_store_index,
    output logic [dcache_cfg_pkg::ADDR_W-1:0]   o_wb_addr,
    output logic [dcache_cfg_pkg::ADDR_W-1:0]   o_miss_addr,
    output dcache_proto_pkg::line_u             o_wb_line,
    tag_port_if.ctrl                            o_tag,
    data_port_if.ctrl                           o_data
);

    logic [2:0]                               state_q;
    logic [2:0]                               state_d;
    logic                                     load_q;
    logic [dcache_cfg_pkg::ADDR_W-1:0]        addr_q;
    logic [dcache_cfg_pkg::WORD_W-1:0]        st_data_q;
    logic [dcache_cfg_pkg::MASK_W-1:0]        st_mask_q;
    logic [dcache_cfg_pkg::SIDX_W-1:0]        st_idx_q;
    logic [dcache_cfg_pkg::WAY_W-1:0]         vic_way_q;
    logic [dcache_cfg_pkg::TAG_W-1:0]         vic_tag_q;
    logic [dcache_cfg_pkg::WORD_W-1:0]        ld_word_q;
    logic [dcache_cfg_pkg::INDEX_W-1:0]       index;
    logic [dcache_cfg_pkg::TAG_W-1:0]         tag;
    logic [$clog2(dcache_cfg_pkg::WORDS)-1:0] word_sel;
    logic                                     in_lookup;
    logic                                     hit_now;
    logic                                     refill_now;

    assign index    = addr_q[dcache_cfg_pkg::OFF_W +: dcache_cfg_pkg::INDEX_W];
    assign tag      = addr_q[dcache_cfg_pkg::ADDR_W-1 -: dcache_cfg_pkg::TAG_W];
    assign word_sel = addr_q[dcache_cfg_pkg::OFF_W-1 : $clog2(dcache_cfg_pkg::MASK_W)];

    assign in_lookup  = (state_q == dcache_proto_pkg::ST_LOOKUP);
    assign hit_now    = in_lookup && o_tag.hit;
    assign refill_now = (state_q == dcache_proto_pkg::ST_MISS) && i_l2_refill_valid;

    ////////////////////
    // FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_proto_pkg::ST_IDLE:   if (i_req_valid) state_d = dcache_proto_pkg::ST_LOOKUP;
            dcache_proto_pkg::ST_LOOKUP: begin
                if (o_tag.hit)
                    state_d = dcache_proto_pkg::ST_RESP;
                else if (o_tag.victim_valid && o_tag.victim_dirty)
                    state_d = dcache_proto_pkg::ST_WB;  // evict first
                else
                    state_d = dcache_proto_pkg::ST_MISS;
            end
            dcache_proto_pkg::ST_WB:     state_d = dcache_proto_pkg::ST_MISS;
            dcache_proto_pkg::ST_MISS:   if (i_l2_refill_valid) state_d = dcache_proto_pkg::ST_RESP;
            default:                     state_d = dcache_proto_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge w_Selector2_fire_2 or negedge rstn) begin
        if (!rstn) begin
            state_q <= dcache_proto_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////
    // request, victim and load word
    always_ff @(posedge w_Selector2_fire_2) begin
        if (o_req_ready && i_req_valid) begin
            load_q    <= i_req_load;
            addr_q    <= i_req_addr;
            st_data_q <= i_store_data;
            st_mask_q <= i_store_mask;
            st_idx_q  <= i_store_index;
        end
        if (in_lookup) begin
            vic_way_q <= o_tag.victim_way;
            vic_tag_q <= o_tag.victim_tag;
        end
        if (hit_now)
            ld_word_q <= o_data.rd_line.words[word_sel];
        else if (refill_now)
            ld_word_q <= i_l2_refill_line.words[word_sel];   // answered from the refill
    end

    // tag side
    assign o_tag.index         = index;
    assign o_tag.tag           = tag;
    assign o_tag.lookup        = in_lookup;
    assign o_tag.fill          = refill_now;
    assign o_tag.fill_way      = vic_way_q;
    assign o_tag.fill_dirty    = !load_q;
    assign o_tag.set_dirty     = hit_now && !load_q;
    assign o_tag.set_dirty_way = o_tag.hit_way;

    // data side
    assign o_data.index       = index;
    assign o_data.way         = in_lookup ? o_tag.hit_way : vic_way_q;
    assign o_data.rd_way      = in_lookup ? o_tag.hit_way : vic_way_q;
    assign o_data.refill_we   = refill_now;
    assign o_data.refill_line = i_l2_refill_line;
    assign o_data.word_we     = !load_q && (hit_now || refill_now);
    assign o_data.word_sel    = word_sel;
    assign o_data.word_data   = st_data_q;
    assign o_data.byte_mask   = st_mask_q;

    ////////////////////
    // outputs
    assign o_req_ready   = (state_q == dcache_proto_pkg::ST_IDLE);
    assign o_load_valid  = (state_q == dcache_proto_pkg::ST_RESP) && load_q;
    assign o_store_done  = (state_q == dcache_proto_pkg::ST_RESP) && !load_q;
    assign o_load_data   = ld_word_q;
    assign o_store_index = st_idx_q;
    assign o_wb_valid    = (state_q == dcache_proto_pkg::ST_WB);
    assign o_wb_addr     = {vic_tag_q, index, {dcache_cfg_pkg::OFF_W{1'b0}}};
    assign o_wb_line     = o_data.rd_line;                  // victim way read
    assign o_miss_valid  = (state_q == dcache_proto_pkg::ST_MISS);
    assign o_miss_addr   = {tag, index, {dcache_cfg_pkg::OFF_W{1'b0}}};

    // the refilled line is not in the set yet
    a_refill_no_hit: assert property (@(posedge w_Selector2_fire_2) disable iff (!rstn)
        refill_now |-> !o_tag.hit)
        else $error("dcache_ctrl: refill of a line already present in set %0d", index);

endmodule

// ==== dcache_data_array.sv ====
`timescale 1ns/1ps

module dcache_data_array (
    input  logic       w_Selector2_fire_2,
    data_port_if.array i_data
);

    dcache_proto_pkg::line_u line_mem [dcache_cfg_pkg::SETS][dcache_cfg_pkg::WAYS];
    dcache_proto_pkg::line_u wr_line;

    // combinational read of one way
    assign i_data.rd_line = line_mem[i_data.index][i_data.rd_way];

    ////////////////////
    // write data
    // refill replaces the line; a store on top of it merges its bytes
    always_comb begin
        wr_line = i_data.refill_we ? i_data.refill_line : line_mem[i_data.index][i_data.way];
        for (int b = 0; b < dcache_cfg_pkg::MASK_W; b++) begin
            if (i_data.word_we && i_data.byte_mask[b]) begin
                wr_line.bytes[int'(i_data.word_sel) * dcache_cfg_pkg::MASK_W + b] =
                    i_data.word_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge w_Selector2_fire_2) begin
        if (i_data.refill_we || i_data.word_we) begin
            line_mem[i_data.index][i_data.way] <= wr_line;
        end
    end

    // the store mask comes from the request, held by the controller
    a_mask_set: assert property (@(posedge w_Selector2_fire_2)
        i_data.word_we |-> (i_data.byte_mask != '0))
        else $error("dcache_data_array: word write with empty byte mask");

endmodule

// ==== dcache_tag_array.sv ====
`timescale 1ns/1ps

module dcache_tag_array (
    input  logic      w_Selector2_fire_2,
    input  logic      rstn,
    tag_port_if.array i_tag
);

    logic [dcache_cfg_pkg::TAG_W-1:0] tag_mem [dcache_cfg_pkg::SETS][dcache_cfg_pkg::WAYS];
    logic [dcache_cfg_pkg::SETS-1:0][dcache_cfg_pkg::WAYS-1:0]   valid_q;
    logic [dcache_cfg_pkg::SETS-1:0][dcache_cfg_pkg::WAYS-1:0]   dirty_q;
    logic [dcache_cfg_pkg::SETS-1:0][dcache_cfg_pkg::PLRU_W-1:0] plru_q;

    logic [dcache_cfg_pkg::WAYS-1:0]   set_valid;
    logic [dcache_cfg_pkg::WAYS-1:0]   hit_vec;
    logic [dcache_cfg_pkg::PLRU_W-1:0] tree;
    logic [dcache_cfg_pkg::WAY_W-1:0]  plru_way;
    logic [dcache_cfg_pkg::WAY_W-1:0]  free_way;
    logic [dcache_cfg_pkg::WAY_W-1:0]  victim;
    logic                              any_free;

    // point every node on the way's path away from it
    function automatic logic [dcache_cfg_pkg::PLRU_W-1:0] plru_touch(
        input logic [dcache_cfg_pkg::PLRU_W-1:0] t,
        input logic [dcache_cfg_pkg::WAY_W-1:0]  w
    );
        logic [dcache_cfg_pkg::PLRU_W-1:0] n;
        n = t;
        n[0] = ~w[2];                       // root
        n[1 + int'(w[2])] = ~w[1];          // half node
        n[3 + int'(w[2:1])] = ~w[0];        // pair leaf
        return n;
    endfunction

    ////////////////////
    // compare and victim choice
    always_comb begin
        tree      = plru_q[i_tag.index];
        set_valid = valid_q[i_tag.index];
        i_tag.hit_way = '0;
        free_way  = '0;
        any_free  = 1'b0;
        // walk down so the lowest invalid way wins
        for (int w = dcache_cfg_pkg::WAYS - 1; w >= 0; w--) begin
            hit_vec[w] = set_valid[w] && (tag_mem[i_tag.index][w] == i_tag.tag);
            if (hit_vec[w]) begin
                i_tag.hit_way = dcache_cfg_pkg::WAY_W'(w);
            end
            if (!set_valid[w]) begin
                free_way = dcache_cfg_pkg::WAY_W'(w);
                any_free = 1'b1;
            end
        end
        i_tag.hit = |hit_vec;

        plru_way[2] = tree[0];
        plru_way[1] = tree[0] ? tree[2] : tree[1];
        plru_way[0] = tree[3 + int'(plru_way[2:1])];
        victim = any_free ? free_way : plru_way;

        i_tag.victim_way   = victim;
        i_tag.victim_valid = set_valid[victim];
        i_tag.victim_dirty = dirty_q[i_tag.index][victim];
        i_tag.victim_tag   = tag_mem[i_tag.index][victim];
    end

    ////////////////////
    // state bits and trees
    always_ff @(posedge w_Selector2_fire_2 or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
            plru_q  <= '0;
        end else begin
            if (i_tag.lookup && i_tag.hit) begin
                plru_q[i_tag.index] <= plru_touch(tree, i_tag.hit_way);
            end
            if (i_tag.fill) begin
                valid_q[i_tag.index][i_tag.fill_way] <= 1'b1;
                dirty_q[i_tag.index][i_tag.fill_way] <= i_tag.fill_dirty;
                plru_q[i_tag.index] <= plru_touch(tree, i_tag.fill_way);
            end
            if (i_tag.set_dirty) begin
                dirty_q[i_tag.index][i_tag.set_dirty_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge w_Selector2_fire_2) begin
        if (i_tag.fill) begin
            tag_mem[i_tag.index][i_tag.fill_way] <= i_tag.tag;
        end
    end

    // a refill never installs a tag already present in the set
    a_one_hit: assert property (@(posedge w_Selector2_fire_2) disable iff (!rstn)
        i_tag.lookup |-> $onehot0(hit_vec))
        else $error("dcache_tag_array: several ways hit in set %0d", i_tag.index);

endmodule

// ==== dcache_array_if.sv ====
`timescale 1ns/1ps

// controller <-> tag/state array
interface tag_port_if;
    logic [dcache_cfg_pkg::INDEX_W-1:0] index;
    logic [dcache_cfg_pkg::TAG_W-1:0]   tag;
    logic                               lookup;         // plru touch on hit
    logic                               fill;
    logic [dcache_cfg_pkg::WAY_W-1:0]   fill_way;
    logic                               fill_dirty;     // store refill lands dirty
    logic                               set_dirty;
    logic [dcache_cfg_pkg::WAY_W-1:0]   set_dirty_way;
    logic                               hit;
    logic [dcache_cfg_pkg::WAY_W-1:0]   hit_way;
    logic [dcache_cfg_pkg::WAY_W-1:0]   victim_way;
    logic                               victim_valid;
    logic                               victim_dirty;
    logic [dcache_cfg_pkg::TAG_W-1:0]   victim_tag;

    modport ctrl (output index, tag, lookup, fill, fill_way, fill_dirty, set_dirty,
                  set_dirty_way,
                  input hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag);
    modport array (input index, tag, lookup, fill, fill_way, fill_dirty, set_dirty,
                   set_dirty_way,
                   output hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag);
endinterface

// controller <-> line storage
interface data_port_if;
    logic [dcache_cfg_pkg::INDEX_W-1:0]         index;
    logic [dcache_cfg_pkg::WAY_W-1:0]           way;        // write way
    logic [dcache_cfg_pkg::WAY_W-1:0]           rd_way;
    logic                                       refill_we;
    dcache_proto_pkg::line_u                    refill_line;
    logic                                       word_we;
    logic [$clog2(dcache_cfg_pkg::WORDS)-1:0]   word_sel;
    logic [dcache_cfg_pkg::WORD_W-1:0]          word_data;
    logic [dcache_cfg_pkg::MASK_W-1:0]          byte_mask;
    dcache_proto_pkg::line_u                    rd_line;

    modport ctrl (output index, way, rd_way, refill_we, refill_line, word_we, word_sel,
                  word_data, byte_mask, input rd_line);
    modport array (input index, way, rd_way, refill_we, refill_line, word_we, word_sel,
                   word_data, byte_mask, output rd_line);
endinterface

// ==== dcache_proto_pkg.sv ====
package dcache_proto_pkg;

    ////////////////////
    // one cache line
    // words view for load select and writeback,
    // bytes view for the masked store merge
    typedef union packed {
        logic [dcache_cfg_pkg::WORDS-1:0][dcache_cfg_pkg::WORD_W-1:0] words;
        logic [dcache_cfg_pkg::LINE_W/8-1:0][7:0]                    bytes;
    } line_u;

    ////////////////////
    // controller states
    localparam logic [2:0] ST_IDLE   = 3'd0;   // ready for a request
    localparam logic [2:0] ST_LOOKUP = 3'd1;   // tag compare
    localparam logic [2:0] ST_WB     = 3'd2;   // dirty victim out
    localparam logic [2:0] ST_MISS   = 3'd3;   // waiting on L2
    localparam logic [2:0] ST_RESP   = 3'd4;   // response pulse

endpackage

// ==== dcache_cfg_pkg.sv ====
package dcache_cfg_pkg;

    ////////////////////
    // address split: tag | index | offset
    localparam int ADDR_W  = 34;
    localparam int TAG_W   = 24;    // bits 33..10
    localparam int INDEX_W = 5;     // bits 9..5
    localparam int OFF_W   = 5;     // bits 4..0

    ////////////////////
    // organisation
    localparam int SETS    = 32;
    localparam int WAYS    = 8;
    localparam int WAY_W   = 3;
    localparam int WORD_W  = 32;
    localparam int WORDS   = 8;     // words per line
    localparam int LINE_W  = 256;

    // tree pseudo-LRU, one tree per set
    localparam int PLRU_W  = 7;

    ////////////////////
    // store side
    localparam int MASK_W  = 4;     // one bit per byte of the word
    localparam int SIDX_W  = 6;

endpackage
